/* Bender.yml */
package:
  name: trig_seq

sources:
  - files:
      - verilog/trig_seq_pkg.sv
      - verilog/trig_seq_cfg_if.sv
      - verilog/trig_seq_evt_if.sv
      - verilog/trig_seq_regs.sv
      - verilog/trig_edge_detect.sv
      - verilog/trigger_sequencer.sv
      - verilog/trig_event_counters.sv
      - verilog/trig_seq_top.sv
  - target: test
    files:
      - tb/trig_seq_assert.sv
      - tb/trig_seq_tb.sv

/* compile.f */
verilog/trig_seq_pkg.sv
verilog/trig_seq_cfg_if.sv
verilog/trig_seq_evt_if.sv
verilog/trig_seq_regs.sv
verilog/trig_edge_detect.sv
verilog/trigger_sequencer.sv
verilog/trig_event_counters.sv
verilog/trig_seq_top.sv
tb/trig_seq_assert.sv
tb/trig_seq_tb.sv

/* tb/trig_seq_assert.sv */
`timescale 1ns/10ps

module trig_seq_assert (
  input logic                                  adc_clk,
  input logic                                  reset,
  input logic                                  bypass,
  input logic                                  trig_out,
  input logic                                  too_late,
  input logic [trig_seq_pkg::NUM_TRIGGERS-1:0] active_step,
  input trig_seq_pkg::seq_state_t              state
);
  import trig_seq_pkg::*;

  int fail_cnt = 0;

  a_single_pulse: assert property (
    @(posedge adc_clk) disable iff (reset)
    (!bypass && trig_out) |=> (bypass || !trig_out)
  ) else begin
    fail_cnt++;
    $error("trig_out high for more than one cycle in sequence mode");
  end

  // step 0 is the only one awaited in wait_first
  a_onehot_step: assert property (
    @(posedge adc_clk) disable iff (reset)
    !bypass |-> $onehot(active_step) &&
                (state != wait_first || active_step == NUM_TRIGGERS'(1))
  ) else begin
    fail_cnt++;
    $error("active_step not one-hot, or not step 0 in wait_first, with bypass clear");
  end

  a_idle_after_late: assert property (
    @(posedge adc_clk) disable iff (reset)
    too_late |=> (state == idle)
  ) else begin
    fail_cnt++;
    $error("sequencer not idle the cycle after too_late");
  end

endmodule

bind trigger_sequencer trig_seq_assert seq_assert_inst (
  .adc_clk     (adc_clk),
  .reset       (reset),
  .bypass      (cfg.bypass),
  .trig_out    (trig_out),
  .too_late    (too_late),
  .active_step (active_step),
  .state       (state_q)
);

/* tb/trig_seq_tb.sv */
`timescale 1ns/10ps

module trig_seq_tb;
  import trig_seq_pkg::*;

  typedef struct {
    bit          arm;
    bit          bypass;
    logic [1:0]  last_step;
    logic [31:0] win [1:3];  // {max_wait, min_wait}
    int          n_trig;
    int          idx [0:5];
    int          gap [0:5];  // cycles since the previous rise
    int          pulses;
    int          d_seq;
    int          d_late;
    int          d_early;
  } row_t;

  localparam int NUM_ROWS = 7;

  logic                    adc_clk;
  logic                    reset;
  logic [APB_AW-1:0]       paddr;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [APB_DW-1:0]       pwdata;
  logic [APB_DW-1:0]       prdata;
  logic [NUM_TRIGGERS-1:0] trig_in;
  logic                    trig_out;
  logic [NUM_TRIGGERS-1:0] active_step;

  row_t rows [0:NUM_ROWS-1];
  int   pulse_total = 0;  // rising edges of trig_out so far
  logic trig_out_prev = 1'b0;
  bit   bypass_on = 1'b0;
  int   exp_seq = 0;
  int   exp_late = 0;
  int   exp_early = 0;

  trig_seq_top trig_seq_top_inst (
    .adc_clk     (adc_clk),
    .reset       (reset),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .trig_in     (trig_in),
    .trig_out    (trig_out),
    .active_step (active_step)
  );

  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else fail_now($sformatf("ERROR time %0t: %s is 0x%0h, expected 0x%0h",
                              $time, name, got, exp));
  endtask

  // a failed concurrent assertion ends the run at once
  always @(trig_seq_top_inst.trigger_sequencer_inst.seq_assert_inst.fail_cnt) begin
    if (trig_seq_top_inst.trigger_sequencer_inst.seq_assert_inst.fail_cnt != 0) begin
      fail_now("a concurrent assertion on the sequencer failed");
    end
  end

  // sampled mid-cycle, away from both edges of the trigger path
  always @(negedge adc_clk) begin
    if (!reset && trig_out && !trig_out_prev) pulse_total++;
    trig_out_prev = trig_out;
    if (bypass_on) begin
      assert (trig_out === trig_in[0])
        else fail_now($sformatf("ERROR time %0t: trig_out is %b, expected %b (trig_in[0])",
                                $time, trig_out, trig_in[0]));
    end
  end

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
    @(posedge adc_clk);
    #1;
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge adc_clk);
    #1;
    penable = 1'b1;
    @(posedge adc_clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
    @(posedge adc_clk);
    #1;
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge adc_clk);
    #1;
    penable = 1'b1;
    @(negedge adc_clk);
    data = prdata;
    @(posedge adc_clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // gap counts edges between this rise and the previous one
  task automatic drive_pulse(input int idx, input int gap);
    repeat (gap - 1) begin
      @(posedge adc_clk);
      #1;
    end
    trig_in[idx] = 1'b1;
    @(posedge adc_clk);
    #1;
    trig_in[idx] = 1'b0;
  endtask

  task automatic wait_armed();
    logic [31:0] st;
    int          n;
    n = 0;
    apb_read(ADDR_STATUS, st);
    while (st[5:4] != wait_first) begin
      n++;
      if (n > 20) fail_now("sequencer did not reach wait_first after arming");
      apb_read(ADDR_STATUS, st);
    end
  endtask

  // settled once the sequencer has left wait_next
  task automatic wait_settled();
    logic [31:0] st;
    int          n;
    n = 0;
    apb_read(ADDR_STATUS, st);
    while (st[5:4] == wait_next) begin
      n++;
      if (n > 100) fail_now("sequencer still in wait_next, row never settled");
      apb_read(ADDR_STATUS, st);
    end
  endtask

  task automatic load_table();
    // full chain, then a two-step chain with a stray input 2
    rows[0] = '{1'b1, 1'b0, 2'd3, '{32'h0028_0005, 32'h0028_0005, 32'h0028_0005}, 4,
                '{0, 1, 2, 3, 0, 0}, '{3, 12, 20, 10, 1, 1}, 1, 1, 0, 0};
    rows[1] = '{1'b1, 1'b0, 2'd1, '{32'h0028_0005, 32'h0, 32'h0}, 3,
                '{0, 2, 1, 0, 0, 0}, '{3, 5, 10, 1, 1, 1}, 1, 1, 0, 0};
    // early step 1 at 8, accepted at 28
    rows[2] = '{1'b1, 1'b0, 2'd1, '{32'h003C_0014, 32'h0, 32'h0}, 3,
                '{0, 1, 1, 0, 0, 0}, '{3, 8, 20, 1, 1, 1}, 1, 1, 0, 1};
    // step 2 never comes, max_wait 30
    rows[3] = '{1'b1, 1'b0, 2'd2, '{32'h0028_0005, 32'h001E_0005, 32'h0}, 2,
                '{0, 1, 0, 0, 0, 0}, '{3, 10, 1, 1, 1, 1}, 0, 0, 1, 0};
    // no upper limit
    rows[4] = '{1'b1, 1'b0, 2'd1, '{32'h0000_0005, 32'h0, 32'h0}, 2,
                '{0, 1, 0, 0, 0, 0}, '{3, 100, 1, 1, 1, 1}, 1, 1, 0, 0};
    rows[5] = '{1'b1, 1'b1, 2'd3, '{32'h0028_0005, 32'h0028_0005, 32'h0028_0005}, 4,
                '{0, 0, 1, 0, 0, 0}, '{3, 5, 4, 6, 1, 1}, 3, 0, 0, 0};
    rows[6] = '{1'b0, 1'b0, 2'd3, '{32'h0028_0005, 32'h0028_0005, 32'h0028_0005}, 4,
                '{0, 1, 2, 3, 0, 0}, '{3, 12, 20, 10, 1, 1}, 0, 0, 0, 0};
  endtask

  task automatic check_regs();
    logic [31:0] rd;
    logic [7:0]  unmapped [0:2];
    unmapped = '{8'h20, 8'h84, 8'hFC};
    apb_write(ADDR_WAIT1, 32'h1234_5678);
    apb_write(ADDR_WAIT2, 32'hA5A5_0F0F);
    apb_write(ADDR_WAIT3, 32'h0001_FFFE);
    apb_write(ADDR_CTRL, 32'h0000_0022);
    apb_read(ADDR_WAIT1, rd);
    check_eq("wait1", rd, 32'h1234_5678);
    apb_read(ADDR_WAIT2, rd);
    check_eq("wait2", rd, 32'hA5A5_0F0F);
    apb_read(ADDR_WAIT3, rd);
    check_eq("wait3", rd, 32'h0001_FFFE);
    apb_read(ADDR_CTRL, rd);
    check_eq("ctrl", rd, 32'h0000_0022);
    apb_read(ADDR_STATUS, rd);
    check_eq("status", rd, 32'h0000_000F);  // bypass, idle
    for (int i = 0; i < 3; i++) begin
      apb_read(unmapped[i], rd);
      check_eq($sformatf("prdata at 0x%0h", unmapped[i]), rd, 32'h0);
    end
    apb_write(ADDR_CTRL, 32'h0000_0031);
    apb_read(ADDR_CTRL, rd);
    check_eq("ctrl", rd, 32'h0000_0031);
  endtask

  task automatic run_row(input int r);
    row_t        row;
    logic [31:0] rd;
    int          start_pulses;
    row = rows[r];
    bypass_on = 1'b0;
    apb_write(ADDR_CTRL, 32'h0);  // back to idle
    for (int i = 1; i < 4; i++) apb_write(ADDR_WAIT1 + 8'(4 * (i - 1)), row.win[i]);
    apb_write(ADDR_CTRL, {26'd0, row.last_step, 2'b00, row.bypass, row.arm});
    bypass_on = row.bypass;
    if (row.arm && !row.bypass) wait_armed();
    start_pulses = pulse_total;
    for (int t = 0; t < row.n_trig; t++) drive_pulse(row.idx[t], row.gap[t]);
    repeat (4 + int'($urandom % 8)) @(posedge adc_clk);
    #1;
    exp_seq   += row.d_seq;
    exp_late  += row.d_late;
    exp_early += row.d_early;
    wait_settled();
    check_eq($sformatf("trig_out pulses, row %0d", r), pulse_total - start_pulses, row.pulses);
    apb_read(ADDR_SEQ_CNT, rd);
    check_eq("seq_cnt", rd, exp_seq);
    apb_read(ADDR_LATE_CNT, rd);
    check_eq("late_cnt", rd, exp_late);
    apb_read(ADDR_EARLY_CNT, rd);
    check_eq("early_cnt", rd, exp_early);
    apb_read(ADDR_STATUS, rd);
    assert (rd[5:4] == idle || rd[5:4] == wait_first)
      else fail_now($sformatf("ERROR time %0t: status state is %0d, expected %0d or %0d",
                              $time, rd[5:4], idle, wait_first));
    if (row.bypass) begin
      check_eq("status active_step", rd[3:0], 4'hF);
      check_eq("active_step", active_step, 4'hF);
    end
  endtask

  initial begin
    logic [31:0] rd;
    void'($urandom(53314));
    reset   = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    trig_in = '0;
    load_table();
    repeat (8) @(posedge adc_clk);
    #1;
    reset = 1'b0;
    check_eq("trig_out", trig_out, 1'b0);
    check_eq("active_step", active_step, 4'b0001);
    apb_read(ADDR_STATUS, rd);
    check_eq("status", rd, 32'h0000_0001);
    check_regs();
    for (int r = 0; r < NUM_ROWS; r++) run_row(r);
    if (trig_seq_top_inst.trigger_sequencer_inst.seq_assert_inst.fail_cnt != 0) begin
      $display("TESTS FAILED");
      $fatal(1, "concurrent assertions reported errors");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

/* verilog/trig_edge_detect.sv */
`timescale 1ns/10ps

module trig_edge_detect (
  input  logic                                  adc_clk,
  input  logic                                  reset,
  input  logic [trig_seq_pkg::NUM_TRIGGERS-1:0] trig_in,
  output logic [trig_seq_pkg::NUM_TRIGGERS-1:0] rise
);
  import trig_seq_pkg::*;

  logic [NUM_TRIGGERS-1:0] trig_s1; // first capture of the raw inputs
  logic [NUM_TRIGGERS-1:0] trig_s2; // delayed copy for edge compare

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      trig_s1 <= '0;
      trig_s2 <= '0;
      rise    <= '0;
    end else begin
      trig_s1 <= trig_in;
      trig_s2 <= trig_s1;
      rise    <= trig_s1 & ~trig_s2; // one cycle per low-to-high
    end
  end

endmodule

/* verilog/trig_event_counters.sv */
`timescale 1ns/10ps

module trig_event_counters (
  input  logic                           adc_clk,
  input  logic                           reset,
  trig_seq_evt_if.cnt                    evt,
  output logic [trig_seq_pkg::CNT_W-1:0] seq_cnt,
  output logic [trig_seq_pkg::CNT_W-1:0] late_cnt,
  output logic [trig_seq_pkg::CNT_W-1:0] early_cnt,
  output trig_seq_pkg::seq_state_t       state
);
  import trig_seq_pkg::*;

  logic [2:0]       strobe;
  logic [CNT_W-1:0] cnt_q [0:2];

  assign strobe = {evt.too_early, evt.too_late, evt.seq_done};

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      for (int i = 0; i < 3; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (strobe[i] && cnt_q[i] != '1) cnt_q[i] <= cnt_q[i] + 1'b1; // hold at all ones
      end
    end
  end

  assign seq_cnt   = cnt_q[0];
  assign late_cnt  = cnt_q[1];
  assign early_cnt = cnt_q[2];
  assign state     = evt.state; // for the status register

endmodule

/* verilog/trig_seq_cfg_if.sv */
`timescale 1ns/10ps

interface trig_seq_cfg_if;
  import trig_seq_pkg::*;

  logic              arm;
  logic              bypass;
  logic [STEP_W-1:0] last_step;
  wait_word_u        wait_win [1:NUM_TRIGGERS-1]; // windows for steps 1..3

  modport regs (
    output arm,
    output bypass,
    output last_step,
    output wait_win
  );

  modport seq (
    input arm,
    input bypass,
    input last_step,
    input wait_win
  );

endinterface

/* verilog/trig_seq_evt_if.sv */
`timescale 1ns/10ps

interface trig_seq_evt_if;
  import trig_seq_pkg::*;

  logic       seq_done;  // one-cycle strobes
  logic       too_late;
  logic       too_early;
  seq_state_t state;

  modport seq (
    output seq_done,
    output too_late,
    output too_early,
    output state
  );

  modport cnt (
    input seq_done,
    input too_late,
    input too_early,
    input state
  );

endinterface

/* verilog/trig_seq_pkg.sv */
package trig_seq_pkg;

  localparam int NUM_TRIGGERS = 4;
  localparam int STEP_W       = 2;
  localparam int WAIT_W       = 16;
  localparam int CNT_W        = 16;
  localparam int APB_AW       = 8;
  localparam int APB_DW       = 32;

  // register map
  localparam logic [APB_AW-1:0] ADDR_CTRL      = 8'h00;
  localparam logic [APB_AW-1:0] ADDR_WAIT1     = 8'h04;
  localparam logic [APB_AW-1:0] ADDR_WAIT2     = 8'h08;
  localparam logic [APB_AW-1:0] ADDR_WAIT3     = 8'h0C;
  localparam logic [APB_AW-1:0] ADDR_STATUS    = 8'h10;
  localparam logic [APB_AW-1:0] ADDR_SEQ_CNT   = 8'h14;
  localparam logic [APB_AW-1:0] ADDR_LATE_CNT  = 8'h18;
  localparam logic [APB_AW-1:0] ADDR_EARLY_CNT = 8'h1C;

  typedef enum logic [1:0] {
    idle       = 2'd0,
    wait_first = 2'd1,
    wait_next  = 2'd2
  } seq_state_t;

  typedef struct packed {
    logic [WAIT_W-1:0] max_wait; // 0 means no upper limit
    logic [WAIT_W-1:0] min_wait;
  } wait_win_t;

  typedef union packed {
    logic [APB_DW-1:0] raw; // bus view
    wait_win_t         win; // window view for the sequencer
  } wait_word_u;

endpackage

/* verilog/trig_seq_regs.sv */
`timescale 1ns/10ps

module trig_seq_regs (
  input  logic                                   adc_clk,
  input  logic                                   reset,
  input  logic [trig_seq_pkg::APB_AW-1:0]        paddr,
  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  logic [trig_seq_pkg::APB_DW-1:0]        pwdata,
  output logic [trig_seq_pkg::APB_DW-1:0]        prdata,
  trig_seq_cfg_if.regs                           cfg,
  input  logic [trig_seq_pkg::NUM_TRIGGERS-1:0]  active_step,
  input  trig_seq_pkg::seq_state_t               state,
  input  logic [trig_seq_pkg::CNT_W-1:0]         seq_cnt,
  input  logic [trig_seq_pkg::CNT_W-1:0]         late_cnt,
  input  logic [trig_seq_pkg::CNT_W-1:0]         early_cnt
);
  import trig_seq_pkg::*;

  logic              arm_q;
  logic              bypass_q;
  logic [STEP_W-1:0] last_step_q;
  wait_word_u        wait_q [1:NUM_TRIGGERS-1];
  logic              wr_en;

  assign wr_en = psel & penable & pwrite; // access phase write

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      arm_q       <= 1'b0;
      bypass_q    <= 1'b0;
      last_step_q <= '0;
      for (int i = 1; i < NUM_TRIGGERS; i++) begin
        wait_q[i].raw <= '0;
      end
    end else if (wr_en) begin
      case (paddr)
        ADDR_CTRL: begin
          arm_q       <= pwdata[0];
          bypass_q    <= pwdata[1];
          last_step_q <= pwdata[5:4];
        end
        ADDR_WAIT1: wait_q[1].raw <= pwdata;
        ADDR_WAIT2: wait_q[2].raw <= pwdata;
        ADDR_WAIT3: wait_q[3].raw <= pwdata;
        default: ;                                 // read-only or unmapped
      endcase
    end
  end

  // read mux, combinational on the address
  always_comb begin
    prdata = '0;
    if (psel) begin
      case (paddr)
        ADDR_CTRL: begin
          prdata[0]   = arm_q;
          prdata[1]   = bypass_q;
          prdata[5:4] = last_step_q;
        end
        ADDR_WAIT1:     prdata = wait_q[1].raw;
        ADDR_WAIT2:     prdata = wait_q[2].raw;
        ADDR_WAIT3:     prdata = wait_q[3].raw;
        ADDR_STATUS: begin
          prdata[NUM_TRIGGERS-1:0] = active_step;
          prdata[5:4]              = state;
        end
        ADDR_SEQ_CNT:   prdata[CNT_W-1:0] = seq_cnt;
        ADDR_LATE_CNT:  prdata[CNT_W-1:0] = late_cnt;
        ADDR_EARLY_CNT: prdata[CNT_W-1:0] = early_cnt;
        default:        prdata = '0;
      endcase
    end
  end

  assign cfg.arm       = arm_q;
  assign cfg.bypass    = bypass_q;
  assign cfg.last_step = last_step_q;

  // windows leave through the struct view of each word
  for (genvar g = 1; g < NUM_TRIGGERS; g++) begin : g_win
    assign cfg.wait_win[g].win = wait_q[g].win;
  end

endmodule

/* verilog/trig_seq_top.sv */
`timescale 1ns/10ps

module trig_seq_top (
  input  logic                                  adc_clk,
  input  logic                                  reset,
  input  logic [trig_seq_pkg::APB_AW-1:0]       paddr,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [trig_seq_pkg::APB_DW-1:0]       pwdata,
  output logic [trig_seq_pkg::APB_DW-1:0]       prdata,
  input  logic [trig_seq_pkg::NUM_TRIGGERS-1:0] trig_in,
  output logic                                  trig_out,
  output logic [trig_seq_pkg::NUM_TRIGGERS-1:0] active_step
);
  import trig_seq_pkg::*;

  logic [NUM_TRIGGERS-1:0] rise;
  logic [CNT_W-1:0]        seq_cnt;
  logic [CNT_W-1:0]        late_cnt;
  logic [CNT_W-1:0]        early_cnt;
  seq_state_t              status_state;

  trig_seq_cfg_if cfg_if ();
  trig_seq_evt_if evt_if ();

  trig_seq_regs trig_seq_regs_inst (
    .adc_clk     (adc_clk),
    .reset       (reset),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .cfg         (cfg_if.regs),
    .active_step (active_step),
    .state       (status_state),
    .seq_cnt     (seq_cnt),
    .late_cnt    (late_cnt),
    .early_cnt   (early_cnt)
  );

  trig_edge_detect trig_edge_detect_inst (
    .adc_clk (adc_clk),
    .reset   (reset),
    .trig_in (trig_in),
    .rise    (rise)
  );

  trigger_sequencer trigger_sequencer_inst (
    .adc_clk     (adc_clk),
    .reset       (reset),
    .trig_in     (trig_in),     // raw input for bypass
    .rise        (rise),
    .cfg         (cfg_if.seq),
    .evt         (evt_if.seq),
    .trig_out    (trig_out),
    .active_step (active_step)
  );

  trig_event_counters trig_event_counters_inst (
    .adc_clk   (adc_clk),
    .reset     (reset),
    .evt       (evt_if.cnt),
    .seq_cnt   (seq_cnt),
    .late_cnt  (late_cnt),
    .early_cnt (early_cnt),
    .state     (status_state)
  );

endmodule

/* verilog/trigger_sequencer.sv */
`timescale 1ns/10ps

module trigger_sequencer (
  input  logic                                  adc_clk,
  input  logic                                  reset,
  input  logic [trig_seq_pkg::NUM_TRIGGERS-1:0] trig_in,
  input  logic [trig_seq_pkg::NUM_TRIGGERS-1:0] rise,
  trig_seq_cfg_if.seq                           cfg,
  trig_seq_evt_if.seq                           evt,
  output logic                                  trig_out,
  output logic [trig_seq_pkg::NUM_TRIGGERS-1:0] active_step
);
  import trig_seq_pkg::*;

  seq_state_t        state_q;
  seq_state_t        state_nxt;
  logic [STEP_W-1:0] step_q;     // index of the awaited input
  logic [STEP_W-1:0] step_inc;
  logic [WAIT_W-1:0] wait_cnt;   // cycles since last accepted edge
  wait_win_t         next_win;   // window of the awaited step
  wait_win_t         load_win;
  logic              seq_en;
  logic              step_rise;
  logic              accept;
  logic              fire;
  logic              seq_done_q;
  logic              too_late;
  logic              too_early;

  assign seq_en    = cfg.arm & ~cfg.bypass;
  assign step_inc  = step_q + 1'b1;
  assign step_rise = rise[step_q];

  // window for the step after the one being accepted
  always_comb begin
    load_win = '0;
    for (int i = 1; i < NUM_TRIGGERS; i++) begin
      if (step_inc == i) load_win = cfg.wait_win[i].win;
    end
  end

  always_comb begin
    state_nxt = state_q;
    accept    = 1'b0;
    fire      = 1'b0;
    too_late  = 1'b0;
    too_early = 1'b0;
    case (state_q)
      idle: begin
        if (seq_en) state_nxt = wait_first;
      end
      wait_first: begin
        if (!seq_en) begin
          state_nxt = idle;
        end else if (step_rise) begin
          accept = 1'b1;
          if (cfg.last_step == '0) begin // single-step sequence
            fire      = 1'b1;
            state_nxt = idle;
          end else begin
            state_nxt = wait_next;
          end
        end
      end
      wait_next: begin
        if (!seq_en) begin
          state_nxt = idle;
        end else if (step_rise) begin
          if (wait_cnt >= next_win.min_wait) begin
            accept = 1'b1;
            if (step_q == cfg.last_step) begin
              fire      = 1'b1;
              state_nxt = idle;
            end
          end else begin
            too_early = 1'b1; // keep waiting
          end
        end else if (next_win.max_wait != '0 && wait_cnt == next_win.max_wait) begin
          too_late  = 1'b1;
          state_nxt = idle;
        end
      end
      default: state_nxt = idle;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      state_q    <= idle;
      step_q     <= '0;
      seq_done_q <= 1'b0;
    end else begin
      state_q    <= state_nxt;
      seq_done_q <= fire;
      if (state_q == idle) step_q <= '0;
      else if (accept && !fire) step_q <= step_inc;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (state_q == idle) next_win <= cfg.wait_win[1].win;
    else if (accept) next_win <= load_win;
    if (accept) wait_cnt <= WAIT_W'(1);
    else if (state_q == wait_next) wait_cnt <= wait_cnt + 1'b1;
  end

  assign evt.seq_done  = seq_done_q;
  assign evt.too_late  = too_late;
  assign evt.too_early = too_early;
  assign evt.state     = state_q;

  assign trig_out    = cfg.bypass ? trig_in[0] : seq_done_q;
  assign active_step = cfg.bypass ? '1 : ({{(NUM_TRIGGERS-1){1'b0}}, 1'b1} << step_q);

endmodule
